// ==== pcs_tx_top.f ====
+incdir+include
design/pcs_pkg.sv
design/pcs_reset_ctrl.sv
design/xgmii_decode.sv
design/block_encode.sv
design/tx_scrambler.sv
design/pcs_tx_top.sv
verif/pcs_tx_sva.sv
verif/pcs_tx_tb.sv

// ==== verif/pcs_tx_tb.sv ====
`include "pcs_defs.svh"

module pcs_tx_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ROWS         = 20;
  localparam int HOLDOFF        = 1 << (`PCS_HOLDOFF_BITS - 1);
  localparam int TIMEOUT_CYCLES = 20 * N_ROWS + HOLDOFF + 50;
  localparam logic [63:0] TERM_TYPES = {`PCS_BT_TERM7, `PCS_BT_TERM6, `PCS_BT_TERM5,
                                        `PCS_BT_TERM4, `PCS_BT_TERM3, `PCS_BT_TERM2,
                                        `PCS_BT_TERM1, `PCS_BT_TERM0};

  logic        refclk_bufh;
  logic        gttxreset_txusrclk2;
  logic        in_valid;
  logic        in_ready;
  logic [63:0] xgmii_txd;
  logic [7:0]  xgmii_txc;
  logic        out_valid;
  logic        out_ready;
  logic [1:0]  out_header;
  logic [63:0] out_payload;
  logic        tx_ready;

  integer      seed = 32'h352e;
  logic        rand_ready = 1'b0;
  logic [57:0] scr_model = '1;
  logic [65:0] exp_q[$];
  int          acc_q[$];
  int          cycle_cnt = 0;
  int          out_count = 0;
  int          mismatch_errs = 0;
  int          other_errs = 0;

  pcs_tx_top i_pcs_tx_top
  (
    .refclk_bufh         (refclk_bufh),
    .gttxreset_txusrclk2 (gttxreset_txusrclk2),
    .in_valid            (in_valid),
    .in_ready            (in_ready),
    .xgmii_txd           (xgmii_txd),
    .xgmii_txc           (xgmii_txc),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .out_header          (out_header),
    .out_payload         (out_payload),
    .tx_ready            (tx_ready)
  );

  initial
  begin
    refclk_bufh = 1'b0;
    forever #5 refclk_bufh = ~refclk_bufh;
  end

  // ******************************
  // stimulus table, {txc, txd}.
  // ******************************
  function automatic logic [71:0] stim_row(input int i);
    case (i)
      0:  return {8'h00, 64'h0123456789ABCDEF};
      1:  return {8'h00, 64'hFEDCBA9876543210};
      2:  return {8'hFF, 64'h0707070707070707};
      3:  return {8'h01, 64'hD5555555555555FB};
      4:  return {8'h00, 64'h1122334455667788};
      5:  return {8'hFF, 64'h07070707070707FD};
      6:  return {8'hFE, 64'h070707070707FD11};
      7:  return {8'hFC, 64'h0707070707FD2211};
      8:  return {8'hF8, 64'h07070707FD332211};
      9:  return {8'hF0, 64'h070707FD44332211};
      10: return {8'hE0, 64'h0707FD5544332211};
      11: return {8'hC0, 64'h07FD665544332211};
      12: return {8'h80, 64'hFD77665544332211};
      13: return {8'hFF, 64'h07070707FE070707};
      14: return {8'h03, 64'hD5555555555555FB};
      15: return {8'hFC, 64'h0707070709FD2211};
      16: return {8'h1F, 64'hD5D5D5FB07070707};
      17: return {8'hFF, 64'h0707070707070707};
      18: return {8'h01, 64'hAABBCCDDEEFF00FB};
      default: return {8'h00, 64'hFFFFFFFFFFFFFFFF};
    endcase
  endfunction

  // reference encoder, returns {header, payload}.
  function automatic logic [65:0] model_encode(input logic [63:0] d, input logic [7:0] c);
    logic [55:0] rest;
    logic        all_idle;
    logic        above_idle;
    int          term_lane;
    all_idle  = 1'b1;
    term_lane = -1;
    for (int i = 0; i < 8; i++)
      all_idle &= (d[8*i +: 8] == `PCS_CHAR_IDLE);
    for (int k = 0; k < 8; k++)
    begin
      above_idle = 1'b1;
      for (int j = k + 1; j < 8; j++)
        above_idle &= (d[8*j +: 8] == `PCS_CHAR_IDLE);
      if (c == (8'hFF << k) && d[8*k +: 8] == `PCS_CHAR_TERM && above_idle)
        term_lane = k;
    end
    if (c == 8'h00)
      return {2'b01, d};
    if (c == 8'hFF && all_idle)
      return {2'b10, {8{`PCS_CTRL_IDLE}}, `PCS_BT_IDLE};
    if (c == 8'h01 && d[7:0] == `PCS_CHAR_START)
      return {2'b10, d[63:8], `PCS_BT_START0};
    if (term_lane >= 0)
    begin
      rest = {8{`PCS_CTRL_IDLE}};
      for (int i = 0; i < term_lane; i++)
        rest[8*i +: 8] = d[8*i +: 8];
      return {2'b10, rest, TERM_TYPES[8*term_lane +: 8]};
    end
    return {2'b10, {8{`PCS_CTRL_ERROR}}, `PCS_BT_IDLE};
  endfunction

  // lsb first, output bit fed back.
  task automatic scramble_model(input logic [63:0] p, output logic [63:0] s);
    logic b;
    for (int i = 0; i < 64; i++)
    begin
      b = p[i] ^ scr_model[`PCS_SCR_TAP_A] ^ scr_model[`PCS_SCR_TAP_B];
      s[i] = b;
      scr_model = {scr_model[56:0], b};
    end
  endtask

  task automatic accept_row();
    logic [65:0] enc;
    logic [63:0] scr;
    enc = model_encode(xgmii_txd, xgmii_txc);
    scramble_model(enc[63:0], scr);
    exp_q.push_back({enc[65:64], scr});
    acc_q.push_back(rand_ready ? -1 : cycle_cnt);
  endtask

  task automatic check_output();
    logic [65:0] exp;
    int          acc;
    out_count++;
    if (exp_q.size() == 0)
    begin
      $display("unexpected output block at time %0t", $time);
      other_errs++;
    end
    else
    begin
      exp = exp_q.pop_front();
      acc = acc_q.pop_front();
      assert (out_header == exp[65:64])
      else
      begin
        $display("Mismatch at time %0t: out_header got %b expected %b",
                 $time, out_header, exp[65:64]);
        mismatch_errs++;
      end
      assert (out_payload == exp[63:0])
      else
      begin
        $display("Mismatch at time %0t: out_payload got %h expected %h",
                 $time, out_payload, exp[63:0]);
        mismatch_errs++;
      end
      assert (acc < 0 || cycle_cnt - acc == 3)
      else
      begin
        $display("block came out %0d cycles after acceptance instead of 3", cycle_cnt - acc);
        other_errs++;
      end
    end
  endtask

  task automatic check_holdoff();
    for (int i = 0; i <= HOLDOFF; i++)
    begin
      @(negedge refclk_bufh);
      assert (!tx_ready && !in_ready)
      else
      begin
        $display("tx_ready or in_ready rose %0d cycles after reset, too early", i);
        other_errs++;
      end
      @(posedge refclk_bufh);
    end
    @(negedge refclk_bufh);
    assert (tx_ready)
    else
    begin
      $display("tx_ready still low after the hold-off");
      other_errs++;
    end
    @(posedge refclk_bufh);
  endtask

  task automatic send_row(input logic [71:0] row);
    in_valid  <= 1'b1;
    xgmii_txc <= row[71:64];
    xgmii_txd <= row[63:0];
    @(negedge refclk_bufh);
    while (!in_ready)
      @(negedge refclk_bufh);
    @(posedge refclk_bufh);
  endtask

  task automatic run_table();
    for (int i = 0; i < N_ROWS; i++)
      send_row(stim_row(i));
    in_valid <= 1'b0;
    while (exp_q.size() != 0)
      @(posedge refclk_bufh);
    @(negedge refclk_bufh);
  endtask

  always @(posedge refclk_bufh)
  begin
    cycle_cnt++;
    if (rand_ready)
      out_ready <= $random(seed);
    else
      out_ready <= 1'b1;
  end

  // ******************************
  // monitor, sampled mid-cycle.
  // ******************************
  always @(negedge refclk_bufh)
  begin
    if (gttxreset_txusrclk2)
    begin
      assert (!tx_ready && !in_ready && !out_valid)
      else
      begin
        $display("tx_ready, in_ready or out_valid high during reset");
        other_errs++;
      end
    end
    else
    begin
      if (out_valid && out_ready)
        check_output();
      if (in_valid && in_ready)
        accept_row();
    end
  end

  initial
  begin
    while (cycle_cnt < TIMEOUT_CYCLES)
      @(negedge refclk_bufh);
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d mismatches, %0d other, %0d assertion", mismatch_errs,
             other_errs + 1, i_pcs_tx_top.i_pcs_tx_sva.fail_count);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    gttxreset_txusrclk2 = 1'b1;
    in_valid            = 1'b0;
    xgmii_txd           = '0;
    xgmii_txc           = '0;
    out_ready           = 1'b1;
    repeat (3) @(posedge refclk_bufh);
    gttxreset_txusrclk2 <= 1'b0;
    check_holdoff();
    run_table();
    // second pass under back-pressure.
    rand_ready = 1'b1;
    @(posedge refclk_bufh);
    run_table();
    // pipeline empty, nothing more may come out.
    repeat (8) @(negedge refclk_bufh);
    assert (out_count == 2 * N_ROWS)
    else
    begin
      $display("%0d blocks came out, %0d were accepted", out_count, 2 * N_ROWS);
      other_errs++;
    end
    $display("errors: %0d mismatches, %0d other, %0d assertion", mismatch_errs, other_errs,
             i_pcs_tx_top.i_pcs_tx_sva.fail_count);
    if (mismatch_errs == 0 && other_errs == 0 && i_pcs_tx_top.i_pcs_tx_sva.fail_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verif/pcs_tx_sva.sv ====
`include "pcs_defs.svh"

module pcs_tx_sva
(
  input logic        refclk_bufh,
  input logic        gttxreset_txusrclk2,
  input logic        out_valid,
  input logic        out_ready,
  input logic [1:0]  out_header,
  input logic [63:0] out_payload,
  input logic        tx_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HOLD_CYCLES = (1 << (`PCS_HOLDOFF_BITS - 1)) + 1;

  int fail_count = 0;

  // output block held while the sink stalls.
  property p_hold_on_stall;
    @(posedge refclk_bufh) disable iff (gttxreset_txusrclk2)
      (out_valid && !out_ready) |=>
        (out_valid && $stable(out_header) && $stable(out_payload));
  endproperty

  property p_quiet_in_reset;
    @(posedge refclk_bufh) gttxreset_txusrclk2 |-> (!out_valid && !tx_ready);
  endproperty

  // tx_ready low through the hold-off, high right after.
  property p_holdoff_then_ready;
    @(posedge refclk_bufh) disable iff (gttxreset_txusrclk2)
      $fell(gttxreset_txusrclk2) |-> !tx_ready [*HOLD_CYCLES] ##1 tx_ready;
  endproperty

  a_hold_on_stall: assert property (p_hold_on_stall)
    else
    begin
      $error("output block changed during a stall");
      fail_count++;
    end
  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else
    begin
      $error("out_valid or tx_ready high during reset");
      fail_count++;
    end
  a_holdoff_then_ready: assert property (p_holdoff_then_ready)
    else
    begin
      $error("tx_ready did not rise right after the hold-off");
      fail_count++;
    end

endmodule

bind pcs_tx_top pcs_tx_sva i_pcs_tx_sva (.*);

// ==== design/pcs_tx_top.sv ====
module pcs_tx_top
(
  input  logic        refclk_bufh,
  input  logic        gttxreset_txusrclk2,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [63:0] xgmii_txd,
  input  logic [7:0]  xgmii_txc,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [1:0]  out_header,
  output logic [63:0] out_payload,
  output logic        tx_ready
);

  import pcs_pkg::*;

  logic         stall;
  logic         stage_en;
  logic         in_fire;
  logic         dec_valid;
  blk_class_e   dec_class;
  logic [2:0]   dec_term_lane;
  logic [63:0]  dec_txd;
  logic         enc_valid;
  logic [1:0]   enc_header;
  blk_payload_u enc_payload;

  // ******************************
  // pipeline control.
  // ******************************
  // whole pipe holds while the output waits.
  assign stall    = out_valid && !out_ready;
  assign stage_en = !stall;
  assign in_ready = tx_ready && !stall;
  assign in_fire  = in_valid && in_ready;

  pcs_reset_ctrl i_pcs_reset_ctrl
  (
    .refclk_bufh         (refclk_bufh),
    .gttxreset_txusrclk2 (gttxreset_txusrclk2),
    .tx_ready            (tx_ready)
  );

  xgmii_decode i_xgmii_decode
  (
    .refclk_bufh         (refclk_bufh),
    .gttxreset_txusrclk2 (gttxreset_txusrclk2),
    .enable              (stage_en),
    .in_valid            (in_fire),
    .xgmii_txd           (xgmii_txd),
    .xgmii_txc           (xgmii_txc),
    .dec_valid           (dec_valid),
    .dec_class           (dec_class),
    .dec_term_lane       (dec_term_lane),
    .dec_txd             (dec_txd)
  );

  block_encode i_block_encode
  (
    .refclk_bufh         (refclk_bufh),
    .gttxreset_txusrclk2 (gttxreset_txusrclk2),
    .enable              (stage_en),
    .dec_valid           (dec_valid),
    .dec_class           (dec_class),
    .dec_term_lane       (dec_term_lane),
    .dec_txd             (dec_txd),
    .enc_valid           (enc_valid),
    .enc_header          (enc_header),
    .enc_payload         (enc_payload)
  );

  tx_scrambler i_tx_scrambler
  (
    .refclk_bufh         (refclk_bufh),
    .gttxreset_txusrclk2 (gttxreset_txusrclk2),
    .enable              (stage_en),
    .enc_valid           (enc_valid),
    .enc_header          (enc_header),
    .enc_payload         (enc_payload),
    .out_valid           (out_valid),
    .out_header          (out_header),
    .out_payload         (out_payload)
  );

endmodule

// ==== design/tx_scrambler.sv ====
`include "pcs_defs.svh"

module tx_scrambler
(
  input  logic                  refclk_bufh,
  input  logic                  gttxreset_txusrclk2,
  input  logic                  enable,
  input  logic                  enc_valid,
  input  logic [1:0]            enc_header,
  input  pcs_pkg::blk_payload_u enc_payload,
  output logic                  out_valid,
  output logic [1:0]            out_header,
  output logic [63:0]           out_payload
);

  localparam int SCR_W = `PCS_SCR_TAP_B + 1;

  logic [SCR_W-1:0] scr_state;
  logic [SCR_W-1:0] scr_work;
  logic [SCR_W-1:0] scr_next;
  logic [63:0]      scr_payload;
  logic             load;

  assign load = enable && enc_valid;

  // ******************************
  // x^58 + x^39 + 1, lsb first.
  // ******************************
  always_comb
  begin
    scr_work = scr_state;
    for (int i = 0; i < 64; i++)
    begin
      scr_payload[i] = enc_payload[i] ^ scr_work[`PCS_SCR_TAP_A] ^
                       scr_work[`PCS_SCR_TAP_B];
      scr_work = {scr_work[SCR_W-2:0], scr_payload[i]};
    end
    scr_next = scr_work;
  end

  // state moves only with a loaded block.
  always_ff @(posedge refclk_bufh or posedge gttxreset_txusrclk2)
  begin
    if (gttxreset_txusrclk2)
    begin
      scr_state <= '1;
      out_valid <= 1'b0;
    end
    else if (enable)
    begin
      out_valid <= enc_valid;
      if (enc_valid)
      begin
        scr_state <= scr_next;
      end
    end
  end

  // output register, header unscrambled.
  always_ff @(posedge refclk_bufh)
  begin
    if (load)
    begin
      out_header  <= enc_header;
      out_payload <= scr_payload;
    end
  end

endmodule

// ==== design/block_encode.sv ====
`include "pcs_defs.svh"

module block_encode
(
  input  logic                  refclk_bufh,
  input  logic                  gttxreset_txusrclk2,
  input  logic                  enable,
  input  logic                  dec_valid,
  input  pcs_pkg::blk_class_e   dec_class,
  input  logic [2:0]            dec_term_lane,
  input  logic [63:0]           dec_txd,
  output logic                  enc_valid,
  output logic [1:0]            enc_header,
  output pcs_pkg::blk_payload_u enc_payload
);

  import pcs_pkg::*;

  localparam logic [1:0] HDR_DATA = 2'b01;
  localparam logic [1:0] HDR_CTRL = 2'b10;

  logic [1:0]   header_next;
  blk_payload_u payload_next;
  logic [7:0]   term_type;
  logic [55:0]  term_mask;
  logic [55:0]  idle_fill;
  logic [55:0]  error_fill;

  assign idle_fill  = {8{`PCS_CTRL_IDLE}};
  assign error_fill = {8{`PCS_CTRL_ERROR}};

  // data bytes below the terminate lane.
  assign term_mask = (56'h1 << (8 * dec_term_lane)) - 56'h1;

  always_comb
  begin
    case (dec_term_lane)
      3'd0: term_type = `PCS_BT_TERM0;
      3'd1: term_type = `PCS_BT_TERM1;
      3'd2: term_type = `PCS_BT_TERM2;
      3'd3: term_type = `PCS_BT_TERM3;
      3'd4: term_type = `PCS_BT_TERM4;
      3'd5: term_type = `PCS_BT_TERM5;
      3'd6: term_type = `PCS_BT_TERM6;
      default: term_type = `PCS_BT_TERM7;
    endcase
  end

  // ******************************
  // block assembly.
  // ******************************
  always_comb
  begin
    header_next  = HDR_CTRL;
    payload_next = '0;
    case (dec_class)
      CLS_DATA:
      begin
        header_next = HDR_DATA;
        for (int i = 0; i < 8; i++)
        begin
          payload_next.data_view[i] = dec_txd[8*i +: 8];
        end
      end
      CLS_IDLE:
      begin
        payload_next.ctrl_view.btype = `PCS_BT_IDLE;
        payload_next.ctrl_view.rest  = idle_fill;
      end
      CLS_START:
      begin
        // lane 0 start char replaced by the type.
        payload_next.ctrl_view.btype = `PCS_BT_START0;
        payload_next.ctrl_view.rest  = dec_txd[63:8];
      end
      CLS_TERM:
      begin
        payload_next.ctrl_view.btype = term_type;
        payload_next.ctrl_view.rest  = (dec_txd[55:0] & term_mask) |
                                       (idle_fill & ~term_mask);
      end
      default:
      begin
        payload_next.ctrl_view.btype = `PCS_BT_IDLE;
        payload_next.ctrl_view.rest  = error_fill;
      end
    endcase
  end

  always_ff @(posedge refclk_bufh or posedge gttxreset_txusrclk2)
  begin
    if (gttxreset_txusrclk2)
    begin
      enc_valid <= 1'b0;
    end
    else if (enable)
    begin
      enc_valid <= dec_valid;
    end
  end

  always_ff @(posedge refclk_bufh)
  begin
    if (enable)
    begin
      enc_header  <= header_next;
      enc_payload <= payload_next;
    end
  end

endmodule

// ==== design/xgmii_decode.sv ====
`include "pcs_defs.svh"

module xgmii_decode
(
  input  logic                refclk_bufh,
  input  logic                gttxreset_txusrclk2,
  input  logic                enable,
  input  logic                in_valid,
  input  logic [63:0]         xgmii_txd,
  input  logic [7:0]          xgmii_txc,
  output logic                dec_valid,
  output pcs_pkg::blk_class_e dec_class,
  output logic [2:0]          dec_term_lane,
  output logic [63:0]         dec_txd
);

  import pcs_pkg::*;

  logic [7:0] lane_idle;
  logic [7:0] lane_term;
  logic [7:0] term_ok;
  blk_class_e class_next;
  logic [2:0] lane_next;

  // per-lane character match.
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      lane_idle[i] = (xgmii_txd[8*i +: 8] == `PCS_CHAR_IDLE);
      lane_term[i] = (xgmii_txd[8*i +: 8] == `PCS_CHAR_TERM);
    end
  end

  // terminate in lane k.
  // control from k upward, idles above it.
  always_comb
  begin
    for (int k = 0; k < 8; k++)
    begin
      term_ok[k] = (xgmii_txc == (8'hFF << k)) && lane_term[k] &&
                   (&(lane_idle | ~(8'hFE << k)));
    end
  end

  // ******************************
  // word classification.
  // ******************************
  always_comb
  begin
    class_next = CLS_ERROR;
    lane_next  = 3'd0;
    if (xgmii_txc == 8'h00)
    begin
      class_next = CLS_DATA;
    end
    else if ((xgmii_txc == 8'hFF) && (&lane_idle))
    begin
      class_next = CLS_IDLE;
    end
    else if ((xgmii_txc == 8'h01) && (xgmii_txd[7:0] == `PCS_CHAR_START))
    begin
      class_next = CLS_START;
    end
    else
    begin
      for (int k = 0; k < 8; k++)
      begin
        if (term_ok[k])
        begin
          class_next = CLS_TERM;
          lane_next  = 3'(k);
        end
      end
    end
  end

  always_ff @(posedge refclk_bufh or posedge gttxreset_txusrclk2)
  begin
    if (gttxreset_txusrclk2)
    begin
      dec_valid <= 1'b0;
    end
    else if (enable)
    begin
      dec_valid <= in_valid;
    end
  end

  // payload side.
  always_ff @(posedge refclk_bufh)
  begin
    if (enable)
    begin
      dec_class     <= class_next;
      dec_term_lane <= lane_next;
      dec_txd       <= xgmii_txd;
    end
  end

endmodule

// ==== design/pcs_reset_ctrl.sv ====
`include "pcs_defs.svh"

module pcs_reset_ctrl
(
  input  logic refclk_bufh,
  input  logic gttxreset_txusrclk2,
  output logic tx_ready
);

  localparam int CNT_W = `PCS_HOLDOFF_BITS;

  logic [CNT_W-1:0] holdoff_cnt;
  logic             holdoff_done;

  assign holdoff_done = holdoff_cnt[CNT_W-1];

  // count up after reset, stop once the top bit sets.
  always_ff @(posedge refclk_bufh or posedge gttxreset_txusrclk2)
  begin
    if (gttxreset_txusrclk2)
    begin
      holdoff_cnt <= '0;
    end
    else if (!holdoff_done)
    begin
      holdoff_cnt <= holdoff_cnt + 1'b1;
    end
  end

  // ready one edge after the hold-off.
  always_ff @(posedge refclk_bufh or posedge gttxreset_txusrclk2)
  begin
    if (gttxreset_txusrclk2)
    begin
      tx_ready <= 1'b0;
    end
    else if (holdoff_done)
    begin
      tx_ready <= 1'b1;
    end
  end

endmodule

// ==== design/pcs_pkg.sv ====
package pcs_pkg;

  // ******************************
  // block classes from the decoder.
  // ******************************
  typedef enum logic [3:0] {
    CLS_DATA  = 4'd0,
    CLS_IDLE  = 4'd1,
    CLS_START = 4'd2,
    CLS_TERM  = 4'd3,
    CLS_ERROR = 4'd4
  } blk_class_e;

  // ******************************
  // 64-bit block payload.
  // ******************************

  // data block, lane 0 in the low byte.
  typedef logic [7:0][7:0] blk_data_t;

  // control block, type field sent first.
  typedef struct packed {
    logic [55:0] rest;
    logic [7:0]  btype;
  } blk_ctrl_t;

  // the same 64 bits seen either way.
  typedef union packed {
    blk_data_t data_view;
    blk_ctrl_t ctrl_view;
  } blk_payload_u;

endpackage

// ==== include/pcs_defs.svh ====
`ifndef PCS_DEFS_SVH
`define PCS_DEFS_SVH

// ******************************
// xgmii control characters.
// ******************************
`define PCS_CHAR_IDLE   8'h07
`define PCS_CHAR_START  8'hFB
`define PCS_CHAR_TERM   8'hFD
`define PCS_CHAR_ERROR  8'hFE

// ******************************
// 64b/66b block type field.
// ******************************
`define PCS_BT_IDLE     8'h1E
`define PCS_BT_START0   8'h78
`define PCS_BT_TERM0    8'h87
`define PCS_BT_TERM1    8'h99
`define PCS_BT_TERM2    8'hAA
`define PCS_BT_TERM3    8'hB4
`define PCS_BT_TERM4    8'hCC
`define PCS_BT_TERM5    8'hD2
`define PCS_BT_TERM6    8'hE1
`define PCS_BT_TERM7    8'hFF

// 7-bit control codes inside a block.
`define PCS_CTRL_IDLE   7'h00
`define PCS_CTRL_ERROR  7'h1E

// hold-off ends when the top counter bit sets.
`define PCS_HOLDOFF_BITS 5

// taps for x^39 and x^58.
`define PCS_SCR_TAP_A   38
`define PCS_SCR_TAP_B   57

`endif
